//--- verilog/snn_types_pkg.sv
/*
 * Neuron datapath types
 * Widths, value types and the integrate/leak arithmetic limits
 */
`default_nettype none

package snn_types_pkg;

    localparam int WEIGHT_W = 4;
    localparam int POT_W    = 9;
    localparam int COUNT_W  = 16;

    typedef logic signed [WEIGHT_W-1:0] weight_t;
    typedef logic signed [POT_W-1:0]    potential_t;
    // Only compared against non-negative potentials
    typedef logic [POT_W-1:0]           threshold_t;
    typedef logic [COUNT_W-1:0]         count_t;

    // Saturation limits of the membrane potential
    localparam potential_t POT_MAX = 9'sd255;
    localparam potential_t POT_MIN = -9'sd256;

    // One leak tick moves a potential this far toward zero
    localparam potential_t LEAK_STEP = 9'sd1;

endpackage

`default_nettype wire

//--- verilog/snn_ctrl_pkg.sv
/*
 * Controller definitions
 * Sweep FSM states, update operations and pipeline depth
 */
`default_nettype none

package snn_ctrl_pkg;

    typedef enum logic [2:0] {
        IDLE,
        SWEEP_EVENT,
        SWEEP_LEAK,
        DRAIN,
        ACK_HOLD
    } ctrl_state_t;

    typedef enum logic {
        OP_INTEGRATE,
        OP_LEAK
    } upd_op_t;

    // Updates still in flight after the issue cycle
    localparam int PIPE_DEPTH = 2;

endpackage

`default_nettype wire

//--- verilog/neuron_bus_if.sv
/*
 * Neuron update bus
 * Carries one update from the controller through weight memory to the neurons
 */
`default_nettype none

interface neuron_bus_if #(
    parameter int N_NEURONS = 16,
    parameter int N_INPUTS  = 256
);
    localparam int NEUR_W = $clog2(N_NEURONS);
    localparam int IN_W   = $clog2(N_INPUTS);

    // Issue stage
    logic                    issue_valid;
    snn_ctrl_pkg::upd_op_t   issue_op;
    logic [NEUR_W-1:0]       issue_idx;
    logic [IN_W-1:0]         issue_in_addr;

    // Weight read stage
    logic                    stage_valid;
    snn_ctrl_pkg::upd_op_t   stage_op;
    logic [NEUR_W-1:0]       stage_idx;
    snn_types_pkg::weight_t  stage_weight;

    // Neuron result
    logic                    fire_valid;
    logic [NEUR_W-1:0]       fire_idx;

    modport ctrl (
        output issue_valid, issue_op, issue_idx, issue_in_addr,
        input  stage_valid, fire_valid
    );

    modport mem (
        input  issue_valid, issue_op, issue_idx, issue_in_addr,
        output stage_valid, stage_op, stage_idx, stage_weight
    );

    modport neur (
        input  stage_valid, stage_op, stage_idx, stage_weight,
        output fire_valid, fire_idx
    );

endinterface

`default_nettype wire

//--- verilog/snn_controller.sv
/*
 * SNN controller
 * Four-phase AER input handshake, leak tick arbitration and the neuron sweep FSM
 */
`default_nettype none

module snn_controller #(
    parameter int N_NEURONS = 16,
    parameter int N_INPUTS  = 256,
    localparam int NEUR_W   = $clog2(N_NEURONS),
    localparam int IN_W     = $clog2(N_INPUTS)
) (
    input  logic             CLK,
    input  logic             All_Time_RST_N,
    input  logic [IN_W-1:0]  aer_in_addr,
    input  logic             aer_in_req,
    output logic             aer_in_ack,
    input  logic             leak_tick,
    input  logic             out_room_low,
    neuron_bus_if.ctrl       bus
);

    localparam logic [NEUR_W-1:0] LAST_IDX = NEUR_W'(N_NEURONS - 1);

    snn_ctrl_pkg::ctrl_state_t state;
    snn_ctrl_pkg::upd_op_t     op_q;
    logic [NEUR_W-1:0]         idx;
    logic [IN_W-1:0]           in_addr_q;
    logic                      leak_pend;
    logic                      start_leak;
    logic                      start_event;
    logic                      sweep_issue;

    // ------------------------------
    // Issue decode
    // ------------------------------

    // Leak has priority over a waiting input event
    assign start_leak  = (state == snn_ctrl_pkg::IDLE) && leak_pend && !out_room_low;
    assign start_event = (state == snn_ctrl_pkg::IDLE) && !leak_pend && aer_in_req &&
                         !out_room_low;
    assign sweep_issue = ((state == snn_ctrl_pkg::SWEEP_EVENT) ||
                          (state == snn_ctrl_pkg::SWEEP_LEAK)) && !out_room_low;

    // Neuron 0 goes out in the start cycle itself
    assign bus.issue_valid   = start_leak || start_event || sweep_issue;
    assign bus.issue_op      = (state == snn_ctrl_pkg::IDLE) ?
                               (leak_pend ? snn_ctrl_pkg::OP_LEAK : snn_ctrl_pkg::OP_INTEGRATE) :
                               op_q;
    assign bus.issue_idx     = (state == snn_ctrl_pkg::IDLE) ? '0 : idx;
    assign bus.issue_in_addr = (state == snn_ctrl_pkg::IDLE) ? aer_in_addr : in_addr_q;

    // ------------------------------
    // Sweep FSM
    // ------------------------------
    always_ff @(posedge CLK or negedge All_Time_RST_N) begin
        if (!All_Time_RST_N) begin
            state      <= snn_ctrl_pkg::IDLE;
            op_q       <= snn_ctrl_pkg::OP_INTEGRATE;
            idx        <= '0;
            leak_pend  <= 1'b0;
            aer_in_ack <= 1'b0;
        end else begin
            leak_pend <= leak_tick || (leak_pend && !start_leak);

            case (state)
                snn_ctrl_pkg::IDLE: begin
                    if (start_leak || start_event) begin
                        op_q  <= start_leak ? snn_ctrl_pkg::OP_LEAK : snn_ctrl_pkg::OP_INTEGRATE;
                        idx   <= NEUR_W'(1);
                        state <= start_leak ? snn_ctrl_pkg::SWEEP_LEAK :
                                              snn_ctrl_pkg::SWEEP_EVENT;
                    end
                end
                snn_ctrl_pkg::SWEEP_EVENT,
                snn_ctrl_pkg::SWEEP_LEAK: begin
                    // Hold the index while the output FIFO is short of room
                    if (sweep_issue) begin
                        if (idx == LAST_IDX) begin
                            state <= snn_ctrl_pkg::DRAIN;
                        end else begin
                            idx <= idx + 1'b1;
                        end
                    end
                end
                snn_ctrl_pkg::DRAIN: begin
                    if (!bus.stage_valid && !bus.fire_valid) begin
                        if (op_q == snn_ctrl_pkg::OP_INTEGRATE) begin
                            aer_in_ack <= 1'b1;
                            state      <= snn_ctrl_pkg::ACK_HOLD;
                        end else begin
                            state <= snn_ctrl_pkg::IDLE;
                        end
                    end
                end
                snn_ctrl_pkg::ACK_HOLD: begin
                    // Ack falls only after the sender has dropped req
                    if (!aer_in_req) begin
                        aer_in_ack <= 1'b0;
                        state      <= snn_ctrl_pkg::IDLE;
                    end
                end
                default: begin
                    state <= snn_ctrl_pkg::IDLE;
                end
            endcase
        end
    end

    // Event address for the rest of the sweep
    always_ff @(posedge CLK) begin
        if (start_event) begin
            in_addr_q <= aer_in_addr;
        end
    end

endmodule

`default_nettype wire

//--- verilog/synapse_weight_mem.sv
/*
 * Synaptic weight memory
 * External load port and one registered weight read per issued update
 */
`default_nettype none

module synapse_weight_mem #(
    parameter int N_NEURONS = 16,
    parameter int N_INPUTS  = 256,
    localparam int NEUR_W   = $clog2(N_NEURONS),
    localparam int IN_W     = $clog2(N_INPUTS)
) (
    input  logic                    CLK,
    input  logic                    All_Time_RST_N,
    input  logic                    weight_we,
    input  logic [IN_W-1:0]         weight_in_addr,
    input  logic [NEUR_W-1:0]       weight_idx,
    input  snn_types_pkg::weight_t  weight_data,
    neuron_bus_if.mem               bus
);

    snn_types_pkg::weight_t mem [N_INPUTS][N_NEURONS];

    // Load port, only used between events
    always_ff @(posedge CLK) begin
        if (weight_we) begin
            mem[weight_in_addr][weight_idx] <= weight_data;
        end
    end

    always_ff @(posedge CLK or negedge All_Time_RST_N) begin
        if (!All_Time_RST_N) begin
            bus.stage_valid <= 1'b0;
        end else begin
            bus.stage_valid <= bus.issue_valid;
        end
    end

    // Weight is read for leak updates too, the neurons ignore it
    always_ff @(posedge CLK) begin
        if (bus.issue_valid) begin
            bus.stage_op     <= bus.issue_op;
            bus.stage_idx    <= bus.issue_idx;
            bus.stage_weight <= mem[bus.issue_in_addr][bus.issue_idx];
        end
    end

endmodule

`default_nettype wire

//--- verilog/neuron_array.sv
/*
 * LIF neuron array
 * Membrane potentials with saturating integrate, leak, threshold and reset
 */
`default_nettype none

module neuron_array #(
    parameter int N_NEURONS = 16
) (
    input  logic                       CLK,
    input  logic                       All_Time_RST_N,
    input  snn_types_pkg::threshold_t  threshold,
    neuron_bus_if.neur                 bus
);

    localparam int POT_W = snn_types_pkg::POT_W;

    snn_types_pkg::potential_t pot [N_NEURONS];
    snn_types_pkg::potential_t cur_pot;
    snn_types_pkg::potential_t next_pot;
    logic signed [POT_W:0]     cur_wide;
    logic signed [POT_W:0]     wt_wide;
    logic signed [POT_W:0]     sum_wide;
    logic                      fire_now;

    // One extra bit so the sum can be checked against the limits
    assign cur_pot  = pot[bus.stage_idx];
    assign cur_wide = cur_pot;
    assign wt_wide  = bus.stage_weight;
    assign sum_wide = cur_wide + wt_wide;

    // ------------------------------
    // Update arithmetic
    // ------------------------------
    always_comb begin
        next_pot = cur_pot;
        fire_now = 1'b0;
        if (bus.stage_op == snn_ctrl_pkg::OP_LEAK) begin
            // Step toward zero, never fires
            if (cur_pot > 0) begin
                next_pot = cur_pot - snn_types_pkg::LEAK_STEP;
            end else if (cur_pot < 0) begin
                next_pot = cur_pot + snn_types_pkg::LEAK_STEP;
            end
        end else begin
            if (sum_wide > snn_types_pkg::POT_MAX) begin
                next_pot = snn_types_pkg::POT_MAX;
            end else if (sum_wide < snn_types_pkg::POT_MIN) begin
                next_pot = snn_types_pkg::POT_MIN;
            end else begin
                next_pot = sum_wide[POT_W-1:0];
            end
            fire_now = !next_pot[POT_W-1] &&
                       (snn_types_pkg::threshold_t'(next_pot) >= threshold);
        end
    end

    // Potential store, reset to zero after a spike
    always_ff @(posedge CLK or negedge All_Time_RST_N) begin
        if (!All_Time_RST_N) begin
            for (int i = 0; i < N_NEURONS; i++) begin
                pot[i] <= '0;
            end
            bus.fire_valid <= 1'b0;
        end else begin
            if (bus.stage_valid) begin
                pot[bus.stage_idx] <= fire_now ? '0 : next_pot;
            end
            bus.fire_valid <= bus.stage_valid && fire_now;
        end
    end

    always_ff @(posedge CLK) begin
        if (bus.stage_valid) begin
            bus.fire_idx <= bus.stage_idx;
        end
    end

endmodule

`default_nettype wire

//--- verilog/aer_out_fifo.sv
/*
 * Output spike FIFO
 * Queues fired neuron indices and sends them on the four-phase AER output
 */
`default_nettype none

module aer_out_fifo #(
    parameter int N_NEURONS  = 16,
    parameter int FIFO_DEPTH = 8,
    localparam int NEUR_W    = $clog2(N_NEURONS)
) (
    input  logic               CLK,
    input  logic               All_Time_RST_N,
    input  logic               fire_valid,
    input  logic [NEUR_W-1:0]  fire_idx,
    output logic               out_room_low,
    output logic [NEUR_W-1:0]  aer_out_addr,
    output logic               aer_out_req,
    input  logic               aer_out_ack
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    typedef enum logic [1:0] {
        SEND_IDLE,
        SEND_REQ,
        SEND_ACK_LOW
    } send_state_t;

    logic [NEUR_W-1:0] mem [FIFO_DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    send_state_t       send_state;
    logic              push;
    logic              pop;

    assign push = fire_valid && (count != CNT_W'(FIFO_DEPTH));
    assign pop  = (send_state == SEND_REQ) && aer_out_ack;

    // Room for everything that can still arrive from the pipeline
    assign out_room_low = (CNT_W'(FIFO_DEPTH) - count) < CNT_W'(snn_ctrl_pkg::PIPE_DEPTH + 1);

    // Head entry stays put until the pop at req fall
    assign aer_out_addr = mem[rd_ptr];

    always_ff @(posedge CLK) begin
        if (push) begin
            mem[wr_ptr] <= fire_idx;
        end
    end

    // ------------------------------
    // Pointers and sender FSM
    // ------------------------------
    always_ff @(posedge CLK or negedge All_Time_RST_N) begin
        if (!All_Time_RST_N) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            send_state  <= SEND_IDLE;
            aer_out_req <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(push) - CNT_W'(pop);

            case (send_state)
                SEND_IDLE: begin
                    if (count != '0) begin
                        aer_out_req <= 1'b1;
                        send_state  <= SEND_REQ;
                    end
                end
                SEND_REQ: begin
                    if (aer_out_ack) begin
                        aer_out_req <= 1'b0;
                        send_state  <= SEND_ACK_LOW;
                    end
                end
                SEND_ACK_LOW: begin
                    if (!aer_out_ack) begin
                        send_state <= SEND_IDLE;
                    end
                end
                default: begin
                    send_state <= SEND_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/spike_counter_bank.sv
/*
 * Spike counter bank
 * One wrapping counter per neuron, read back through a select
 */
`default_nettype none

module spike_counter_bank #(
    parameter int N_NEURONS = 16,
    localparam int NEUR_W   = $clog2(N_NEURONS)
) (
    input  logic                    CLK,
    input  logic                    All_Time_RST_N,
    input  logic                    fire_valid,
    input  logic [NEUR_W-1:0]       fire_idx,
    input  logic [NEUR_W-1:0]       count_sel,
    output snn_types_pkg::count_t   spike_count
);

    snn_types_pkg::count_t cnt [N_NEURONS];

    always_ff @(posedge CLK or negedge All_Time_RST_N) begin
        if (!All_Time_RST_N) begin
            for (int i = 0; i < N_NEURONS; i++) begin
                cnt[i] <= '0;
            end
        end else if (fire_valid) begin
            // Wraps at overflow
            cnt[fire_idx] <= cnt[fire_idx] + 1'b1;
        end
    end

    assign spike_count = cnt[count_sel];

endmodule

`default_nettype wire

//--- verilog/snn_core_top.sv
/*
 * Spiking neuron core
 * Controller, weight memory, LIF neurons, output FIFO and spike counters
 */
`default_nettype none

module snn_core_top #(
    parameter int N_NEURONS  = 16,
    parameter int N_INPUTS   = 256,
    parameter int FIFO_DEPTH = 8,
    localparam int NEUR_W    = $clog2(N_NEURONS),
    localparam int IN_W      = $clog2(N_INPUTS)
) (
    input  logic                       CLK,
    input  logic                       All_Time_RST_N,
    // AER input
    input  logic [IN_W-1:0]            aer_in_addr,
    input  logic                       aer_in_req,
    output logic                       aer_in_ack,
    // AER output
    output logic [NEUR_W-1:0]          aer_out_addr,
    output logic                       aer_out_req,
    input  logic                       aer_out_ack,
    // Neuron control
    input  logic                       leak_tick,
    input  snn_types_pkg::threshold_t  threshold,
    // Weight load
    input  logic                       weight_we,
    input  logic [IN_W-1:0]            weight_in_addr,
    input  logic [NEUR_W-1:0]          weight_idx,
    input  snn_types_pkg::weight_t     weight_data,
    // Counter readback
    input  logic [NEUR_W-1:0]          count_sel,
    output snn_types_pkg::count_t      spike_count
);

    logic out_room_low;

    neuron_bus_if #(
        .N_NEURONS (N_NEURONS),
        .N_INPUTS  (N_INPUTS)
    ) i_bus ();

    snn_controller #(
        .N_NEURONS (N_NEURONS),
        .N_INPUTS  (N_INPUTS)
    ) i_ctrl (
        .CLK            (CLK),
        .All_Time_RST_N (All_Time_RST_N),
        .aer_in_addr    (aer_in_addr),
        .aer_in_req     (aer_in_req),
        .aer_in_ack     (aer_in_ack),
        .leak_tick      (leak_tick),
        .out_room_low   (out_room_low),
        .bus            (i_bus.ctrl)
    );

    synapse_weight_mem #(
        .N_NEURONS (N_NEURONS),
        .N_INPUTS  (N_INPUTS)
    ) i_wmem (
        .CLK            (CLK),
        .All_Time_RST_N (All_Time_RST_N),
        .weight_we      (weight_we),
        .weight_in_addr (weight_in_addr),
        .weight_idx     (weight_idx),
        .weight_data    (weight_data),
        .bus            (i_bus.mem)
    );

    neuron_array #(
        .N_NEURONS (N_NEURONS)
    ) i_neur (
        .CLK            (CLK),
        .All_Time_RST_N (All_Time_RST_N),
        .threshold      (threshold),
        .bus            (i_bus.neur)
    );

    // Spikes leave the pipeline here
    aer_out_fifo #(
        .N_NEURONS  (N_NEURONS),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_fifo (
        .CLK            (CLK),
        .All_Time_RST_N (All_Time_RST_N),
        .fire_valid     (i_bus.fire_valid),
        .fire_idx       (i_bus.fire_idx),
        .out_room_low   (out_room_low),
        .aer_out_addr   (aer_out_addr),
        .aer_out_req    (aer_out_req),
        .aer_out_ack    (aer_out_ack)
    );

    spike_counter_bank #(
        .N_NEURONS (N_NEURONS)
    ) i_cnt (
        .CLK            (CLK),
        .All_Time_RST_N (All_Time_RST_N),
        .fire_valid     (i_bus.fire_valid),
        .fire_idx       (i_bus.fire_idx),
        .count_sel      (count_sel),
        .spike_count    (spike_count)
    );

endmodule

`default_nettype wire

//--- tests/snn_core_properties.sv
/*
 * Core handshake properties
 * Four-phase rules on both AER links and the reset state of the outputs
 */
`default_nettype none

module snn_core_properties #(
    parameter int NEUR_W = 4
) (
    input logic              CLK,
    input logic              All_Time_RST_N,
    input logic              aer_in_req,
    input logic              aer_in_ack,
    input logic [NEUR_W-1:0] aer_out_addr,
    input logic              aer_out_req,
    input logic              aer_out_ack,
    input logic [15:0]       spike_count
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_cnt = 0;

    // ------------------------------
    // Reset state
    // ------------------------------
    a_reset_idle: assert property (@(posedge CLK)
        !All_Time_RST_N |-> !aer_in_ack && !aer_out_req)
        else begin
            $error("AER ack or req high while reset is held");
            fail_cnt++;
        end

    a_reset_count: assert property (@(posedge CLK)
        !All_Time_RST_N |-> spike_count == '0)
        else begin
            $error("spike counter not zero while reset is held");
            fail_cnt++;
        end

    // ------------------------------
    // AER input link
    // ------------------------------
    a_in_ack_rise: assert property (@(posedge CLK) disable iff (!All_Time_RST_N)
        $rose(aer_in_ack) |-> $past(aer_in_req))
        else begin
            $error("aer_in_ack rose without aer_in_req");
            fail_cnt++;
        end

    // Ack held until req has gone low
    a_in_ack_fall: assert property (@(posedge CLK) disable iff (!All_Time_RST_N)
        $fell(aer_in_ack) |-> !$past(aer_in_req))
        else begin
            $error("aer_in_ack fell while aer_in_req was high");
            fail_cnt++;
        end

    a_in_ack_drop: assert property (@(posedge CLK) disable iff (!All_Time_RST_N)
        aer_in_ack && !aer_in_req |=> !aer_in_ack)
        else begin
            $error("aer_in_ack stayed high after aer_in_req fell");
            fail_cnt++;
        end

    // ------------------------------
    // AER output link
    // ------------------------------
    a_out_addr_stable: assert property (@(posedge CLK) disable iff (!All_Time_RST_N)
        aer_out_req && $past(aer_out_req) |-> $stable(aer_out_addr))
        else begin
            $error("aer_out_addr changed while aer_out_req was high");
            fail_cnt++;
        end

    a_out_req_hold: assert property (@(posedge CLK) disable iff (!All_Time_RST_N)
        aer_out_req && !aer_out_ack |=> aer_out_req)
        else begin
            $error("aer_out_req fell before aer_out_ack rose");
            fail_cnt++;
        end

    a_out_req_new: assert property (@(posedge CLK) disable iff (!All_Time_RST_N)
        $rose(aer_out_req) |-> !$past(aer_out_ack))
        else begin
            $error("aer_out_req rose before aer_out_ack fell");
            fail_cnt++;
        end

endmodule

`default_nettype wire

//--- tests/tb_clock_gen.sv
/*
 * Testbench clock and reset generator
 */
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS  = 10,
    parameter int RST_CYCLES = 4
) (
    output logic CLK,
    output logic All_Time_RST_N
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        CLK = 1'b0;
        forever begin
            #(PERIOD_NS / 2) CLK = ~CLK;
        end
    end

    // Reset released 1 ns after an edge, in step with the stimulus
    initial begin
        All_Time_RST_N = 1'b0;
        repeat (RST_CYCLES) @(posedge CLK);
        #1 All_Time_RST_N = 1'b1;
    end

endmodule

`default_nettype wire

//--- tests/tb_snn_core.sv
/*
 * Spiking neuron core testbench
 * AER events, leak ticks and weight loads checked against a reference model
 */
`default_nettype none

module tb_snn_core;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int N        = 16;
    localparam int N_LOADED = 10;
    localparam int POT_HI   = 255;
    localparam int POT_LO   = -256;
    localparam int EV_LIMIT = 4000;
    localparam int HS_LIMIT = 100;

    logic        CLK;
    logic        All_Time_RST_N;
    logic [7:0]  aer_in_addr;
    logic        aer_in_req;
    logic        aer_in_ack;
    logic [3:0]  aer_out_addr;
    logic        aer_out_req;
    logic        aer_out_ack;
    logic        leak_tick;
    logic [8:0]  threshold;
    logic        weight_we;
    logic [7:0]  weight_in_addr;
    logic [3:0]  weight_idx;
    logic [3:0]  weight_data;
    logic [3:0]  count_sel;
    logic [15:0] spike_count;

    // Reference model state
    int          pot_m [N];
    int          cnt_m [N];
    int          wmodel [N_LOADED][N];
    int          exp_q [$];
    logic [31:0] main_lfsr = 32'hf35f;
    logic [31:0] recv_lfsr = 32'hf35f;
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    int          recv_total = 0;
    int          ack_wait = 0;
    logic        long_acks = 1'b0;

    tb_clock_gen #(.PERIOD_NS(10), .RST_CYCLES(4)) i_clk (
        .CLK            (CLK),
        .All_Time_RST_N (All_Time_RST_N)
    );

    snn_core_top i_dut (
        .CLK            (CLK),
        .All_Time_RST_N (All_Time_RST_N),
        .aer_in_addr    (aer_in_addr),
        .aer_in_req     (aer_in_req),
        .aer_in_ack     (aer_in_ack),
        .aer_out_addr   (aer_out_addr),
        .aer_out_req    (aer_out_req),
        .aer_out_ack    (aer_out_ack),
        .leak_tick      (leak_tick),
        .threshold      (threshold),
        .weight_we      (weight_we),
        .weight_in_addr (weight_in_addr),
        .weight_idx     (weight_idx),
        .weight_data    (weight_data),
        .count_sel      (count_sel),
        .spike_count    (spike_count)
    );

    bind snn_core_top snn_core_properties #(.NEUR_W(NEUR_W)) i_props (
        .CLK            (CLK),
        .All_Time_RST_N (All_Time_RST_N),
        .aer_in_req     (aer_in_req),
        .aer_in_ack     (aer_in_ack),
        .aer_out_addr   (aer_out_addr),
        .aer_out_req    (aer_out_req),
        .aer_out_ack    (aer_out_ack),
        .spike_count    (spike_count)
    );

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] lfsr_take(inout logic [31:0] state, input int nbits);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < nbits; i++) begin
            val = {val[30:0], state[0]};
            state = state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
        end
        return val;
    endfunction

    task automatic tick();
        @(posedge CLK);
        #1;
    endtask

    task automatic check_value(input string name, input logic [31:0] expv,
                               input logic [31:0] actv);
        checks++;
        assert (actv == expv) else begin
            $display("[FAIL] %s expected 0x%0h actual 0x%0h", name, expv, actv);
            errors++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout while waiting for %s", what);
        errors++;
    endtask

    // ------------------------------
    // Reference model
    // ------------------------------
    task automatic model_event(input int a);
        int s;
        for (int n = 0; n < N; n++) begin
            s = pot_m[n] + wmodel[a][n];
            if (s > POT_HI) begin
                s = POT_HI;
            end else if (s < POT_LO) begin
                s = POT_LO;
            end
            if (s >= 0 && s >= int'(threshold)) begin
                exp_q.push_back(n);
                cnt_m[n]++;
                s = 0;
            end
            pot_m[n] = s;
        end
    endtask

    task automatic model_leak();
        for (int n = 0; n < N; n++) begin
            if (pot_m[n] > 0) begin
                pot_m[n]--;
            end else if (pot_m[n] < 0) begin
                pot_m[n]++;
            end
        end
    endtask

    // ------------------------------
    // Stimulus tasks
    // ------------------------------
    task automatic load_weights();
        int r;
        for (int a = 0; a < N_LOADED; a++) begin
            for (int n = 0; n < N; n++) begin
                if (a < 8) begin
                    r = int'(lfsr_take(main_lfsr, 4));
                    wmodel[a][n] = (r > 7) ? r - 16 : r;
                end else if (a == 8) begin
                    // Even neurons climb, odd neurons sink
                    wmodel[a][n] = n[0] ? -8 : 7;
                end else begin
                    wmodel[a][n] = 7;
                end
                weight_we      = 1'b1;
                weight_in_addr = 8'(a);
                weight_idx     = 4'(n);
                weight_data    = 4'(wmodel[a][n]);
                tick();
            end
        end
        weight_we = 1'b0;
    endtask

    task automatic send_event(input int a);
        int t;
        int hold;
        model_event(a);
        aer_in_addr = 8'(a);
        aer_in_req  = 1'b1;
        t = 0;
        while (!aer_in_ack && t < EV_LIMIT) begin
            tick();
            t++;
        end
        if (!aer_in_ack) begin
            report_timeout("aer_in_ack to rise");
        end
        // Sender keeps req up for a few cycles after ack
        hold = int'(lfsr_take(main_lfsr, 2));
        for (int i = 0; i < hold; i++) begin
            tick();
        end
        aer_in_req = 1'b0;
        t = 0;
        while (aer_in_ack && t < HS_LIMIT) begin
            tick();
            t++;
        end
        if (aer_in_ack) begin
            report_timeout("aer_in_ack to fall");
        end
    endtask

    // The pending tick is served before the next event
    task automatic leak_pulse();
        model_leak();
        leak_tick = 1'b1;
        tick();
        leak_tick = 1'b0;
    endtask

    task automatic wait_drain();
        int t;
        t = 0;
        while ((exp_q.size() != 0 || aer_out_req) && t < EV_LIMIT) begin
            tick();
            t++;
        end
        if (exp_q.size() != 0 || aer_out_req) begin
            report_timeout("the output FIFO to drain");
        end
    endtask

    task automatic check_counts(output int sum);
        sum = 0;
        for (int n = 0; n < N; n++) begin
            count_sel = 4'(n);
            tick();
            check_value($sformatf("spike_count[%0d]", n), cnt_m[n], spike_count);
            sum += int'(spike_count);
        end
    endtask

    task automatic end_test(input string name, input int err_start);
        tests++;
        $display("Test %-12s done, %0d failures", name, errors - err_start);
    endtask

    // ------------------------------
    // AER output receiver
    // ------------------------------
    always @(posedge CLK) begin
        #1;
        if (All_Time_RST_N) begin
            if (aer_out_req && !aer_out_ack) begin
                if (ack_wait > 0) begin
                    ack_wait--;
                end else begin
                    if (exp_q.size() == 0) begin
                        $display("Output address 0x%0h arrived with none predicted",
                                 aer_out_addr);
                        errors++;
                    end else begin
                        check_value("aer_out_addr", exp_q.pop_front(), aer_out_addr);
                    end
                    recv_total++;
                    aer_out_ack = 1'b1;
                end
            end else if (aer_out_ack && !aer_out_req) begin
                aer_out_ack = 1'b0;
                ack_wait = long_acks ? int'(lfsr_take(recv_lfsr, 4)) : 0;
            end
        end
    end

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial begin
        int t;
        int sum;
        int exp_total;
        int err_start;
        aer_in_addr    = '0;
        aer_in_req     = 1'b0;
        aer_out_ack    = 1'b0;
        leak_tick      = 1'b0;
        threshold      = '0;
        weight_we      = 1'b0;
        weight_in_addr = '0;
        weight_idx     = '0;
        weight_data    = '0;
        count_sel      = '0;
        t = 0;
        while (!All_Time_RST_N && t < HS_LIMIT) begin
            tick();
            t++;
        end
        if (!All_Time_RST_N) begin
            report_timeout("reset release");
        end

        err_start = errors;
        check_value("aer_in_ack", 0, aer_in_ack);
        check_value("aer_out_req", 0, aer_out_req);
        check_counts(sum);
        end_test("reset", err_start);

        err_start = errors;
        threshold = 9'd20;
        load_weights();
        for (int i = 0; i < 40; i++) begin
            send_event(int'(lfsr_take(main_lfsr, 3)));
        end
        wait_drain();
        check_counts(sum);
        end_test("integrate", err_start);

        // Drive potentials into both limits, then fire from the top one
        err_start = errors;
        threshold = 9'h1ff;
        for (int i = 0; i < 40; i++) begin
            send_event(8);
        end
        threshold = 9'd250;
        for (int i = 0; i < 4; i++) begin
            send_event(int'(lfsr_take(main_lfsr, 3)));
        end
        wait_drain();
        check_counts(sum);
        end_test("saturation", err_start);

        err_start = errors;
        threshold = 9'd12;
        for (int i = 0; i < 30; i++) begin
            if (lfsr_take(main_lfsr, 1) != 0) begin
                leak_pulse();
            end
            send_event(int'(lfsr_take(main_lfsr, 3)));
        end
        wait_drain();
        check_counts(sum);
        end_test("leak", err_start);

        err_start = errors;
        long_acks = 1'b1;
        threshold = 9'd5;
        for (int i = 0; i < 6; i++) begin
            send_event(9);
        end
        wait_drain();
        check_counts(sum);
        // Every predicted spike since reset
        exp_total = 0;
        for (int n = 0; n < N; n++) begin
            exp_total += cnt_m[n];
        end
        check_value("spike_count sum", exp_total, sum);
        check_value("received address count", exp_total, recv_total);
        long_acks = 1'b0;
        end_test("backpressure", err_start);

        if (i_dut.i_props.fail_cnt != 0) begin
            $display("Bound handshake properties failed %0d times", i_dut.i_props.fail_cnt);
            errors += i_dut.i_props.fail_cnt;
        end

        $display("Summary: tests %0d, checks %0d, failures %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
verilog/snn_types_pkg.sv
verilog/snn_ctrl_pkg.sv
verilog/neuron_bus_if.sv
verilog/snn_controller.sv
verilog/synapse_weight_mem.sv
verilog/neuron_array.sv
verilog/aer_out_fifo.sv
verilog/spike_counter_bank.sv
verilog/snn_core_top.sv
tests/snn_core_properties.sv
tests/tb_clock_gen.sv
tests/tb_snn_core.sv
